// ==== filelist.f ====
hdl/PipePkg.sv
hdl/FwdIf.sv
hdl/InstrIssue.sv
hdl/RegFile.sv
hdl/Forward.sv
hdl/ExecutePipe.sv
hdl/WriteBackPort.sv
hdl/ForwardCore.sv
test/ForwardCore_assertions.sv
test/ForwardCoreTb.sv

// ==== Bender.yml ====
package:
  name: forward_core

sources:
  - hdl/PipePkg.sv
  - hdl/FwdIf.sv
  - hdl/InstrIssue.sv
  - hdl/RegFile.sv
  - hdl/Forward.sv
  - hdl/ExecutePipe.sv
  - hdl/WriteBackPort.sv
  - hdl/ForwardCore.sv
  - target: test
    files:
      - test/ForwardCore_assertions.sv
      - test/ForwardCoreTb.sv

// ==== test/ForwardCoreTb.sv ====
`timescale 1ns/100ps

module ForwardCoreTb;
    import PipePkg::*;

    localparam int DataWidth   = 32;
    localparam int ClkPeriod   = 8;
    localparam int DirectedOps = 31;
    localparam int RandomOps   = 300;
    localparam int TotalOps    = DirectedOps + RandomOps;

    logic                   clk;
    logic                   reset;
    logic                   instrValid;
    logic [31:0]            instrWord;
    logic                   wbValid;
    logic [RegAddrBits-1:0] wbReg;
    logic [DataWidth-1:0]   wbData;
    logic                   brValid;
    logic                   brTaken;

    int          issued;
    int          testCount;
    int          failsBefore;
    logic [31:0] rng;                               // xorshift state

    ForwardCore #(.DataWidth(DataWidth)) DUT (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instrWord(instrWord),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .brValid(brValid), .brTaken(brTaken)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // --------------------------------------------------
    // Encoders and drivers
    // --------------------------------------------------
    function automatic logic [31:0] rType(input functT fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {OpRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        #1;                                         // Drive clear of the edge
        instrValid = 1'b1;
        instrWord  = word;
        issued++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            instrValid = 1'b0;                      // Bubble
        end
    endtask

    task automatic endTest(input string name);
        int fails;
        idle(6);                                    // Past the write-back latency
        fails = DUT.uChecker.failCount - failsBefore;
        failsBefore = DUT.uChecker.failCount;
        testCount++;
        $display("Test %0d %-26s done, %0d assertion failures", testCount, name, fails);
    endtask

    task automatic runRandom();
        logic [RegAddrBits-1:0] rs, rt, rd, prevDst;
        logic [15:0]            imm;
        logic [2:0]             kind;
        prevDst = '0;
        rng     = 32'd14023;
        for (int i = 0; i < RandomOps; i++) begin
            rng = xorshift(rng);
            if (rng[1:0] == 2'b00) begin
                idle(1);
                prevDst = '0;
            end
            rng  = xorshift(rng);
            rs   = {2'b00, rng[2:0]};               // r0..r7 for dense hazards
            rt   = {2'b00, rng[5:3]};
            rd   = {2'b00, rng[8:6]};
            imm  = rng[24:9];
            kind = rng[31:29];
            if (kind == 3'd7 && prevDst != '0 && (prevDst == rs || prevDst == rt)) begin
                idle(1);                            // Keep the BEQ spacing rule
            end
            case (kind)
                3'd0:    issue(rType(FnAdd, rd, rs, rt));
                3'd1:    issue(rType(FnSub, rd, rs, rt));
                3'd2:    issue(rType(FnAnd, rd, rs, rt));
                3'd3:    issue(rType(FnOr, rd, rs, rt));
                3'd4:    issue(rType(FnSlt, rd, rs, rt));
                3'd5:    issue(iType(OpAddi, rd, rs, imm));
                3'd6:    issue(iType(OpOri, rd, rs, imm));
                default: issue(iType(OpBeq, rt, rs, 16'd0));
            endcase
            prevDst = (kind == 3'd7) ? '0 : rd;
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instrValid  = 1'b0;
        instrWord   = '0;
        issued      = 0;
        testCount   = 0;
        failsBefore = 0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        idle(4);                                    // Outputs must stay quiet
        issue(iType(OpAddi, 5'd1, 5'd0, 16'd5));
        endTest("reset and first write");

        // Every result below differs from what a stale register read gives
        issue(iType(OpAddi, 5'd1, 5'd0, 16'h0123));
        issue(iType(OpAddi, 5'd2, 5'd0, 16'hFFFB));
        issue(rType(FnAdd, 5'd3, 5'd1, 5'd2));
        issue(rType(FnSub, 5'd4, 5'd3, 5'd1));
        issue(rType(FnAnd, 5'd5, 5'd4, 5'd4));
        issue(rType(FnOr, 5'd6, 5'd1, 5'd5));
        issue(rType(FnSlt, 5'd7, 5'd6, 5'd0));     // Negative r6 sets r7
        issue(rType(FnSlt, 5'd8, 5'd0, 5'd7));
        endTest("back-to-back ALU chain");

        issue(iType(OpAddi, 5'd9, 5'd0, 16'd11));
        issue(iType(OpOri, 5'd10, 5'd0, 16'd3));
        issue(iType(OpOri, 5'd12, 5'd0, 16'd1));
        issue(rType(FnSub, 5'd11, 5'd9, 5'd10));   // Distance 3 and 2
        issue(iType(OpAddi, 5'd15, 5'd0, 16'd100));
        issue(iType(OpAddi, 5'd15, 5'd15, 16'd1));
        issue(rType(FnAdd, 5'd16, 5'd15, 5'd15));  // Younger r15 must win
        issue(iType(OpAddi, 5'd17, 5'd0, 16'd9));
        idle(1);
        issue(rType(FnAdd, 5'd18, 5'd17, 5'd17));
        endTest("distance 2, 3 and priority");

        issue(iType(OpAddi, 5'd0, 5'd0, 16'd77));
        issue(rType(FnAdd, 5'd19, 5'd0, 5'd0));    // r0 in flight still reads zero
        issue(iType(OpOri, 5'd0, 5'd0, 16'd5));
        issue(iType(OpOri, 5'd20, 5'd0, 16'd0));
        issue(rType(FnAdd, 5'd21, 5'd0, 5'd9));
        endTest("register zero");

        issue(iType(OpAddi, 5'd22, 5'd0, 16'd4));
        issue(iType(OpAddi, 5'd23, 5'd0, 16'd4));
        issue(iType(OpOri, 5'd24, 5'd0, 16'd0));
        issue(iType(OpBeq, 5'd23, 5'd22, 16'd0));  // Taken
        issue(iType(OpAddi, 5'd22, 5'd0, 16'd5));
        issue(iType(OpOri, 5'd25, 5'd0, 16'd1));
        issue(iType(OpBeq, 5'd23, 5'd22, 16'd0));  // Not taken with r22 from EX/MEM
        issue(iType(OpBeq, 5'd0, 5'd0, 16'd0));
        endTest("branch compare");

        runRandom();
        endTest("random stream");

        $display("Summary: %0d tests, %0d instructions, %0d assertion failures",
                 testCount, issued, DUT.uChecker.failCount);
        if (DUT.uChecker.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        #((TotalOps + 20) * ClkPeriod * 2);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== test/ForwardCore_assertions.sv ====
`timescale 1ns/100ps

module ForwardCoreAssertions #(
    parameter int DataWidth = 32
) (
    input logic                            clk,
    input logic                            reset,
    input logic                            instrValid,
    input logic [31:0]                     instrWord,
    input logic                            wbValid,
    input logic [PipePkg::RegAddrBits-1:0] wbReg,
    input logic [DataWidth-1:0]            wbData,
    input logic                            brValid,
    input logic                            brTaken
);
    import PipePkg::*;

    int failCount = 0;                              // Polled by the testbench

    logic [DataWidth-1:0]   shadow [32];            // Architectural state in program order
    logic                   expWbValid [4];         // Slot k holds the op issued k+1 edges ago
    logic [RegAddrBits-1:0] expWbReg   [4];
    logic [DataWidth-1:0]   expWbData  [4];
    logic                   expBrValid [2];
    logic                   expBrTaken [2];
    logic                   prevWrite;              // Op issued on the previous edge writes
    logic [RegAddrBits-1:0] prevDst;

    // --------------------------------------------------
    // Golden model, evaluated at issue
    // --------------------------------------------------
    always @(posedge clk) begin : model
        logic [5:0]             op;
        logic [RegAddrBits-1:0] rs, rt, dst;
        logic [DataWidth-1:0]   a, b, res;
        logic                   wr;
        op  = instrWord[31:26];
        rs  = instrWord[25:21];
        rt  = instrWord[20:16];
        dst = instrWord[15:11];                     // rd unless immediate format
        a   = shadow[rs];
        b   = shadow[rt];
        wr  = 1'b0;
        res = '0;
        case (op)
            OpRType: begin
                wr = 1'b1;
                case (instrWord[5:0])
                    FnAdd:   res = a + b;
                    FnSub:   res = a - b;
                    FnAnd:   res = a & b;
                    FnOr:    res = a | b;
                    FnSlt:   res = ($signed(a) < $signed(b)) ? 1 : 0;
                    default: wr = 1'b0;             // Unknown funct, no write
                endcase
            end
            OpAddi: begin
                wr  = 1'b1;
                dst = rt;
                res = a + DataWidth'($signed(instrWord[15:0]));
            end
            OpOri: begin
                wr  = 1'b1;
                dst = rt;
                res = a | DataWidth'(instrWord[15:0]);  // Zero extended
            end
            default: ;
        endcase

        if (reset) begin
            for (int i = 0; i < 32; i++) shadow[i] <= '0;
            for (int i = 0; i < 4; i++) begin
                expWbValid[i] <= 1'b0;
                expWbReg[i]   <= '0;
                expWbData[i]  <= '0;
            end
            expBrValid[0] <= 1'b0;
            expBrValid[1] <= 1'b0;
            expBrTaken[0] <= 1'b0;
            expBrTaken[1] <= 1'b0;
            prevWrite     <= 1'b0;
            prevDst       <= '0;
        end else begin
            for (int i = 3; i > 0; i--) begin
                expWbValid[i] <= expWbValid[i-1];
                expWbReg[i]   <= expWbReg[i-1];
                expWbData[i]  <= expWbData[i-1];
            end
            expWbValid[0] <= instrValid && wr && (dst != '0);   // r0 writes give no pulse
            expWbReg[0]   <= dst;
            expWbData[0]  <= res;
            expBrValid[1] <= expBrValid[0];
            expBrTaken[1] <= expBrTaken[0];
            expBrValid[0] <= instrValid && (op == OpBeq);
            expBrTaken[0] <= (a == b);
            if (instrValid && wr && (dst != '0)) shadow[dst] <= res;
            prevWrite <= instrValid && wr && (dst != '0);
            prevDst   <= dst;
        end
    end

    // --------------------------------------------------
    // Result checks at the fixed latencies
    // --------------------------------------------------
    aWbValid: assert property (@(posedge clk) disable iff (reset) wbValid == expWbValid[3])
        else begin
            failCount++;
            $error("FAILED at %0t: wbValid expected %b, got %b",
                   $time, $sampled(expWbValid[3]), $sampled(wbValid));
        end

    aWbReg: assert property (@(posedge clk) disable iff (reset) wbValid |-> wbReg == expWbReg[3])
        else begin
            failCount++;
            $error("FAILED at %0t: wbReg expected %0d, got %0d",
                   $time, $sampled(expWbReg[3]), $sampled(wbReg));
        end

    aWbData: assert property (@(posedge clk) disable iff (reset)
                              wbValid |-> wbData == expWbData[3])
        else begin
            failCount++;
            $error("FAILED at %0t: wbData expected %h, got %h",
                   $time, $sampled(expWbData[3]), $sampled(wbData));
        end

    aBrValid: assert property (@(posedge clk) disable iff (reset) brValid == expBrValid[1])
        else begin
            failCount++;
            $error("FAILED at %0t: brValid expected %b, got %b",
                   $time, $sampled(expBrValid[1]), $sampled(brValid));
        end

    aBrTaken: assert property (@(posedge clk) disable iff (reset)
                               brValid |-> brTaken == expBrTaken[1])
        else begin
            failCount++;
            $error("FAILED at %0t: brTaken expected %b, got %b",
                   $time, $sampled(expBrTaken[1]), $sampled(brTaken));
        end

    // No stall logic, so a BEQ may not read the previous op's destination
    aBeqSpacing: assert property (@(posedge clk) disable iff (reset)
        (instrValid && instrWord[31:26] == OpBeq) |->
        !(prevWrite && (prevDst == instrWord[25:21] || prevDst == instrWord[20:16])))
        else begin
            failCount++;
            $error("BEQ at %0t reads a register written by the instruction just before it",
                   $time);
        end

endmodule

bind ForwardCore ForwardCoreAssertions #(.DataWidth(DataWidth)) uChecker (
    .clk(clk), .reset(reset), .instrValid(instrValid), .instrWord(instrWord),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .brValid(brValid), .brTaken(brTaken)
);

// ==== hdl/ForwardCore.sv ====
`timescale 1ns/100ps

module ForwardCore #(
    parameter int DataWidth = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            instrValid,  // One word per strobe
    input  logic [31:0]                     instrWord,
    output logic                            wbValid,
    output logic [PipePkg::RegAddrBits-1:0] wbReg,
    output logic [DataWidth-1:0]            wbData,
    output logic                            brValid,
    output logic                            brTaken
);
    import PipePkg::*;

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    decodedT                decoded;
    logic                   idValid;
    logic [RegAddrBits-1:0] raddrA, raddrB, waddr, memDst;
    logic [DataWidth-1:0]   rdataA, rdataB, wdata, memData;
    logic                   we, memValid, memRegWrite;

    FwdIf fwdBus ();                                // Hazard fields and selects

    InstrIssue #(.DataWidth(DataWidth)) uIssue (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instrWord(instrWord),
        .decoded(decoded), .idValid(idValid)
    );

    RegFile #(.DataWidth(DataWidth)) uRegFile (
        .clk(clk), .reset(reset),
        .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
        .we(we), .waddr(waddr), .wdata(wdata)
    );

    Forward uForward (
        .fwd(fwdBus.unit)
    );

    ExecutePipe #(.DataWidth(DataWidth)) uPipe (
        .clk(clk), .reset(reset), .decoded(decoded), .idValid(idValid),
        .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
        .fwd(fwdBus.pipe), .wbData(wbData),
        .memValid(memValid), .memRegWrite(memRegWrite), .memDst(memDst), .memData(memData),
        .brValid(brValid), .brTaken(brTaken)
    );

    WriteBackPort #(.DataWidth(DataWidth)) uWriteBack (
        .clk(clk), .reset(reset),
        .memValid(memValid), .memRegWrite(memRegWrite), .memDst(memDst), .memData(memData),
        .fwd(fwdBus.wb), .we(we), .waddr(waddr), .wdata(wdata),
        .wbData(wbData), .wbValid(wbValid), .wbReg(wbReg)
    );

endmodule

// ==== hdl/WriteBackPort.sv ====
`timescale 1ns/100ps

module WriteBackPort #(
    parameter int DataWidth = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            memValid,
    input  logic                            memRegWrite,
    input  logic [PipePkg::RegAddrBits-1:0] memDst,
    input  logic [DataWidth-1:0]            memData,
    FwdIf.wb                                fwd,
    output logic                            we,
    output logic [PipePkg::RegAddrBits-1:0] waddr,
    output logic [DataWidth-1:0]            wdata,
    output logic [DataWidth-1:0]            wbData,
    output logic                            wbValid,
    output logic [PipePkg::RegAddrBits-1:0] wbReg
);
    import PipePkg::*;

    // --------------------------------------------------
    // MEM/WB register
    // --------------------------------------------------
    logic                   wbRegWrite;
    logic [RegAddrBits-1:0] wbDst;
    logic [DataWidth-1:0]   wbResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbRegWrite <= 1'b0;
            wbDst      <= '0;
        end else begin
            wbRegWrite <= memValid && memRegWrite;
            wbDst      <= memDst;
        end
    end

    always_ff @(posedge clk) begin
        wbResult <= memData;
    end

    // Forwarding view, Forward skips register 0 itself
    assign fwd.regWriteMemWb = wbRegWrite;
    assign fwd.regDstMemWb   = wbDst;

    assign wbValid = wbRegWrite && (wbDst != '0);   // No pulse for r0 writes
    assign wbReg   = wbDst;
    assign wbData  = wbResult;                      // Also the MEM/WB forward value

    // Register file write at the end of this cycle
    assign we    = wbValid;
    assign waddr = wbDst;
    assign wdata = wbResult;

endmodule

// ==== hdl/ExecutePipe.sv ====
`timescale 1ns/100ps

module ExecutePipe #(
    parameter int DataWidth = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  PipePkg::decodedT                decoded,
    input  logic                            idValid,
    output logic [PipePkg::RegAddrBits-1:0] raddrA,
    output logic [PipePkg::RegAddrBits-1:0] raddrB,
    input  logic [DataWidth-1:0]            rdataA,
    input  logic [DataWidth-1:0]            rdataB,
    FwdIf.pipe                              fwd,
    input  logic [DataWidth-1:0]            wbData,      // MEM/WB value for forwarding
    output logic                            memValid,
    output logic                            memRegWrite,
    output logic [PipePkg::RegAddrBits-1:0] memDst,
    output logic [DataWidth-1:0]            memData,
    output logic                            brValid,
    output logic                            brTaken
);
    import PipePkg::*;

    // ID stage values
    logic [DataWidth-1:0]   idA, idB;
    logic [DataWidth-1:0]   immExt;

    // ID/EX register
    logic                   exValid, exRegWrite, exUseImm;
    logic [RegAddrBits-1:0] exDst, exRs, exRt;
    aluOpT                  exAluOp;
    logic [DataWidth-1:0]   exA, exB, exImm;

    // EX stage values
    logic [DataWidth-1:0]   opA, opB, aluB, aluResult;

    // --------------------------------------------------
    // ID stage
    // --------------------------------------------------
    assign raddrA     = decoded.rs;
    assign raddrB     = decoded.rt;
    assign fwd.rsIfId = decoded.rs;
    assign fwd.rtIfId = decoded.rt;

    assign idA = fwd.fwdAId ? memData : rdataA;     // Distance 2 from EX/MEM
    assign idB = fwd.fwdBId ? memData : rdataB;

    assign immExt = decoded.zeroExt ? DataWidth'(decoded.imm)
                                    : DataWidth'($signed(decoded.imm));

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exUseImm   <= 1'b0;
            exDst      <= '0;
            exRs       <= '0;
            exRt       <= '0;
            exAluOp    <= AluAdd;
            brValid    <= 1'b0;
            brTaken    <= 1'b0;
        end else begin
            exValid    <= idValid;
            exRegWrite <= idValid && decoded.regWrite;  // Bubbles never write
            exUseImm   <= decoded.useImm;
            exDst      <= decoded.dst;
            exRs       <= decoded.rs;
            exRt       <= decoded.rt;
            exAluOp    <= decoded.aluOp;
            brValid    <= idValid && decoded.isBranch;  // One-cycle outcome pulse
            brTaken    <= idValid && decoded.isBranch && (idA == idB);
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        exA   <= idA;
        exB   <= idB;
        exImm <= immExt;
    end

    assign fwd.rsIdEx = exRs;
    assign fwd.rtIdEx = exRt;

    // --------------------------------------------------
    // EX stage
    // --------------------------------------------------
    always_comb begin
        case (fwd.fwdAEx)
            FwdExMem: opA = memData;                // Distance 1
            FwdMemWb: opA = wbData;                 // Distance 2
            default:  opA = exA;
        endcase
        case (fwd.fwdBEx)
            FwdExMem: opB = memData;
            FwdMemWb: opB = wbData;
            default:  opB = exB;
        endcase
        aluB = exUseImm ? exImm : opB;              // Immediate after forwarding

        case (exAluOp)
            AluSub:  aluResult = opA - aluB;
            AluAnd:  aluResult = opA & aluB;
            AluOr:   aluResult = opA | aluB;
            AluSlt:  aluResult = DataWidth'($signed(opA) < $signed(aluB));
            default: aluResult = opA + aluB;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memDst      <= '0;
        end else begin
            memValid    <= exValid;
            memRegWrite <= exRegWrite;
            memDst      <= exDst;
        end
    end

    always_ff @(posedge clk) begin
        memData <= aluResult;
    end

    assign fwd.regWriteExMem = memRegWrite;         // Already qualified by valid
    assign fwd.regDstExMem   = memDst;

endmodule

// ==== hdl/Forward.sv ====
`timescale 1ns/100ps

module Forward (
    FwdIf.unit fwd
);
    import PipePkg::*;

    // A stage can supply src when it writes a non-zero register equal to src
    function automatic logic hits(
        input logic                   regWrite,
        input logic [RegAddrBits-1:0] dst,
        input logic [RegAddrBits-1:0] src
    );
        return regWrite && (dst != '0) && (dst == src);
    endfunction

    always_comb begin
        // --------------------------------------------------
        // ID stage, EX/MEM only
        // --------------------------------------------------
        if (hits(fwd.regWriteExMem, fwd.regDstExMem, fwd.rsIfId))
            fwd.fwdAId = 1'b1;                      // rs from EX/MEM
        else
            fwd.fwdAId = 1'b0;

        if (hits(fwd.regWriteExMem, fwd.regDstExMem, fwd.rtIfId))
            fwd.fwdBId = 1'b1;                      // rt from EX/MEM
        else
            fwd.fwdBId = 1'b0;

        // --------------------------------------------------
        // EX stage, younger EX/MEM ahead of MEM/WB
        // --------------------------------------------------
        if (hits(fwd.regWriteExMem, fwd.regDstExMem, fwd.rsIdEx))
            fwd.fwdAEx = FwdExMem;
        else if (hits(fwd.regWriteMemWb, fwd.regDstMemWb, fwd.rsIdEx))
            fwd.fwdAEx = FwdMemWb;
        else
            fwd.fwdAEx = FwdNone;                   // Value read in ID is current

        if (hits(fwd.regWriteExMem, fwd.regDstExMem, fwd.rtIdEx))
            fwd.fwdBEx = FwdExMem;
        else if (hits(fwd.regWriteMemWb, fwd.regDstMemWb, fwd.rtIdEx))
            fwd.fwdBEx = FwdMemWb;
        else
            fwd.fwdBEx = FwdNone;
    end

endmodule

// ==== hdl/RegFile.sv ====
`timescale 1ns/100ps

module RegFile #(
    parameter int DataWidth = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [PipePkg::RegAddrBits-1:0] raddrA,
    input  logic [PipePkg::RegAddrBits-1:0] raddrB,
    output logic [DataWidth-1:0]            rdataA,
    output logic [DataWidth-1:0]            rdataB,
    input  logic                            we,
    input  logic [PipePkg::RegAddrBits-1:0] waddr,
    input  logic [DataWidth-1:0]            wdata
);
    import PipePkg::*;

    localparam int NumRegs = 1 << RegAddrBits;

    logic [DataWidth-1:0] regs [NumRegs];

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;                   // Entry 0 is never written
        end
    end

    // Read ports, a same-cycle write shows up at once
    always_comb begin
        if (raddrA == '0)                 rdataA = '0;
        else if (we && (waddr == raddrA)) rdataA = wdata;   // Write-through
        else                              rdataA = regs[raddrA];

        if (raddrB == '0)                 rdataB = '0;
        else if (we && (waddr == raddrB)) rdataB = wdata;
        else                              rdataB = regs[raddrB];
    end

endmodule

// ==== hdl/InstrIssue.sv ====
`timescale 1ns/100ps

module InstrIssue #(
    parameter int DataWidth = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             instrValid,
    input  PipePkg::instrT   instrWord,
    output PipePkg::decodedT decoded,
    output logic             idValid
);
    import PipePkg::*;

    instrT word;                                    // IF/ID instruction register

    // Immediates are 16 bits, narrower datapaths cannot hold them
    if (DataWidth < 16) begin : gWidthCheck
        $error("InstrIssue needs DataWidth of at least 16");
    end

    // --------------------------------------------------
    // IF/ID register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            idValid <= 1'b0;
            word    <= '0;                          // All zero decodes as NOP
        end else begin
            idValid <= instrValid;
            if (instrValid) word <= instrWord;      // Hold last word across bubbles
        end
    end

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    always_comb begin
        decoded          = '0;
        decoded.rs       = word.rFmt.rs;            // rs and rt sit at the same bits in both views
        decoded.rt       = word.rFmt.rt;
        decoded.imm      = word.iFmt.imm;
        decoded.aluOp    = AluAdd;
        case (word.rFmt.op)
            OpRType: begin
                decoded.dst      = word.rFmt.rd;
                decoded.regWrite = 1'b1;
                case (word.rFmt.funct)
                    FnAdd:   decoded.aluOp = AluAdd;
                    FnSub:   decoded.aluOp = AluSub;
                    FnAnd:   decoded.aluOp = AluAnd;
                    FnOr:    decoded.aluOp = AluOr;
                    FnSlt:   decoded.aluOp = AluSlt;
                    default: decoded.regWrite = 1'b0; // Unknown funct retires as NOP
                endcase
            end
            OpAddi: begin
                decoded.dst      = word.iFmt.rt;
                decoded.useImm   = 1'b1;            // Sign extended
                decoded.regWrite = 1'b1;
            end
            OpOri: begin
                decoded.dst      = word.iFmt.rt;
                decoded.aluOp    = AluOr;
                decoded.useImm   = 1'b1;
                decoded.zeroExt  = 1'b1;
                decoded.regWrite = 1'b1;
            end
            OpBeq:   decoded.isBranch = 1'b1;       // Compare only, no write
            default: decoded.regWrite = 1'b0;
        endcase
    end

endmodule

// ==== hdl/FwdIf.sv ====
`timescale 1ns/100ps

interface FwdIf;
    import PipePkg::*;

    // --------------------------------------------------
    // Hazard fields from the pipeline registers
    // --------------------------------------------------
    logic                   regWriteExMem;          // Valid write sitting in EX/MEM
    logic [RegAddrBits-1:0] regDstExMem;
    logic                   regWriteMemWb;          // Valid write sitting in MEM/WB
    logic [RegAddrBits-1:0] regDstMemWb;
    logic [RegAddrBits-1:0] rsIdEx, rtIdEx;         // Sources of the op now in EX
    logic [RegAddrBits-1:0] rsIfId, rtIfId;         // Sources of the op now in ID

    // Selects back to the datapath
    fwdExT fwdAEx, fwdBEx;                          // ALU operand muxes
    logic  fwdAId, fwdBId;                          // Branch compare muxes, EX/MEM only

    modport pipe (
        output regWriteExMem, regDstExMem, rsIdEx, rtIdEx, rsIfId, rtIfId,
        input  fwdAEx, fwdBEx, fwdAId, fwdBId
    );

    modport wb (
        output regWriteMemWb, regDstMemWb
    );

    modport unit (
        input  regWriteExMem, regDstExMem, regWriteMemWb, regDstMemWb,
        input  rsIdEx, rtIdEx, rsIfId, rtIfId,
        output fwdAEx, fwdBEx, fwdAId, fwdBId
    );

endinterface

// ==== hdl/PipePkg.sv ====
package PipePkg;

    // --------------------------------------------------
    // Widths fixed by the ISA
    // --------------------------------------------------
    localparam int RegAddrBits = 5;                 // 32 architectural registers

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OpRType = 6'h00,                            // Register format, funct selects op
        OpBeq   = 6'h04,
        OpAddi  = 6'h08,
        OpOri   = 6'h0D
    } opcodeT;

    // Function field of register-format words
    typedef enum logic [5:0] {
        FnAdd = 6'h20,
        FnSub = 6'h22,
        FnAnd = 6'h24,
        FnOr  = 6'h25,
        FnSlt = 6'h2A
    } functT;

    // Same 32-bit word seen in both encodings
    typedef union packed {
        struct packed {
            opcodeT                 op;
            logic [RegAddrBits-1:0] rs;
            logic [RegAddrBits-1:0] rt;
            logic [RegAddrBits-1:0] rd;
            logic [4:0]             shamt;          // Not used by any supported op
            functT                  funct;
        } rFmt;
        struct packed {
            opcodeT                 op;
            logic [RegAddrBits-1:0] rs;
            logic [RegAddrBits-1:0] rt;             // Destination for ADDI and ORI
            logic [15:0]            imm;
        } iFmt;
    } instrT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } aluOpT;

    // Control word handed from issue to the pipe
    typedef struct packed {
        logic [RegAddrBits-1:0] rs;
        logic [RegAddrBits-1:0] rt;
        logic [RegAddrBits-1:0] dst;
        aluOpT                  aluOp;
        logic                   useImm;             // Operand B from imm
        logic                   zeroExt;            // ORI style extension
        logic                   regWrite;
        logic                   isBranch;
        logic [15:0]            imm;
    } decodedT;

    // EX operand source, same codes as the ALU-side mux selects
    typedef enum logic [1:0] {
        FwdNone  = 2'd0,
        FwdExMem = 2'd1,
        FwdMemWb = 2'd2
    } fwdExT;

endpackage
